// ==== all.f ====
rv_isa_pkg.sv
pipe_pkg.sv
gpr_file.sv
forward_unit.sv
ex_alu.sv
ex_branch.sv
ex_stage.sv
exec_core.sv
exec_properties.sv
tb_exec_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/100ps --top-module tb_exec_core \
  -f all.f -o sim_exec_core

./obj_dir/sim_exec_core 2>&1 | tee sim.log || true

if grep -q "test failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// ==== tb_exec_core.sv ====
// testbench for the execute core that checks random instructions and forwarding against a model
`default_nettype none

module tb_exec_core import rv_isa_pkg::*, pipe_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_instr     = 2000;
  localparam int cycle_limit = n_instr * 8;

  logic       clk;
  logic       rst;
  logic       id_to_ex_valid;
  id_to_ex_t  id_to_ex;
  logic       ex_allowin;
  logic       ex_to_mem_valid;
  ex_to_mem_t ex_to_mem;
  logic       mem_allowin;
  fwd_t       mem_fwd;
  fwd_t       wb_fwd;
  bj_ctrl_t   bj_ctrl;

  integer          seed;
  int              cycles;
  int              in_count;
  int              out_count;
  int              out_seen;
  logic [xlen-1:0] shadow [32];
  id_to_ex_t       held_q [$];
  logic            accept_open;
  logic            xfer;
  logic            hold_fwd;

  exec_core #(
    .reg_count (32)
  ) dut_i (
    .clk             (clk),
    .rst             (rst),
    .id_to_ex_valid  (id_to_ex_valid),
    .id_to_ex        (id_to_ex),
    .ex_allowin      (ex_allowin),
    .ex_to_mem_valid (ex_to_mem_valid),
    .ex_to_mem       (ex_to_mem),
    .mem_allowin     (mem_allowin),
    .mem_fwd         (mem_fwd),
    .wb_fwd          (wb_fwd),
    .bj_ctrl         (bj_ctrl)
  );

  always #5 clk = ~clk;

  task automatic stop_on_fail();
    $display("test failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, only %0d of %0d results came out",
               cycles, out_count, n_instr);
      stop_on_fail();
    end
  end

  function automatic logic [xlen-1:0] rand64();
    logic [31:0] hi, lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  // mostly low registers so sources and operands collide often
  function automatic logic [reg_addr_w-1:0] rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[7] ? r[4:0] : {2'b00, r[2:0]};
  endfunction

  function automatic logic rand_bit(int pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 100) < pct;
  endfunction

  function automatic id_to_ex_t new_instr();
    id_to_ex_t   i;
    logic [31:0] r;
    r           = $random(seed);
    i.pc        = rand64();
    i.pc[1:0]   = 2'b00;
    i.rs1_addr  = rand_reg();
    i.rs2_addr  = rand_reg();
    i.use_rs1   = rand_bit(80);
    i.use_rs2   = rand_bit(70);
    i.op1       = rand64();
    i.op2       = rand_bit(15) ? i.op1 : rand64();
    i.is_word   = rand_bit(40);
    i.alu_op    = alu_op_e'(4'(r % 11));
    i.bj_op     = rand_bit(60) ? bj_none : bj_op_e'(4'((r >> 8) % 9));
    i.jmp_imm   = rand64();
    i.is_load   = rand_bit(20);
    i.is_store  = rand_bit(20);
    i.rd_wr_ena = rand_bit(70);
    i.rd_addr   = rand_reg();
    return i;
  endfunction

  function automatic fwd_t new_fwd(int load_pct);
    fwd_t f;
    f.valid   = rand_bit(75);
    f.wr_ena  = rand_bit(80);
    f.rd_addr = rand_reg();
    f.data    = rand64();
    f.is_load = rand_bit(load_pct);
    return f;
  endfunction

  // newest source first and x0 never forwards
  function automatic logic [xlen-1:0] pick_operand(logic [reg_addr_w-1:0] idx);
    if (idx == 0) return '0;
    if (mem_fwd.valid && mem_fwd.wr_ena && mem_fwd.rd_addr == idx) return mem_fwd.data;
    if (wb_fwd.valid && wb_fwd.wr_ena && wb_fwd.rd_addr == idx) return wb_fwd.data;
    return shadow[idx];
  endfunction

  function automatic logic load_stall(id_to_ex_t i);
    logic m1, m2;
    m1 = i.rs1_addr != 0 && mem_fwd.valid && mem_fwd.wr_ena && mem_fwd.rd_addr == i.rs1_addr;
    m2 = i.rs2_addr != 0 && mem_fwd.valid && mem_fwd.wr_ena && mem_fwd.rd_addr == i.rs2_addr;
    return mem_fwd.is_load && ((i.use_rs1 && m1) || (i.use_rs2 && m2));
  endfunction

  // word ops extend the low halves and keep bit 31 as the sign
  function automatic logic [xlen-1:0] model_alu(alu_op_e op, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b, logic word);
    logic [xlen-1:0] x, y, r;
    logic [5:0]      sh;
    x  = a;
    y  = b;
    sh = b[5:0];
    if (word) begin
      x  = (op == alu_srl) ? {32'b0, a[31:0]} : {{32{a[31]}}, a[31:0]};
      y  = {{32{b[31]}}, b[31:0]};
      sh = {1'b0, b[4:0]};
    end
    case (op)
      alu_add:      r = x + y;
      alu_sub:      r = x - y;
      alu_sll:      r = x << sh;
      alu_slt:      r = 64'($signed(x) < $signed(y));
      alu_sltu:     r = 64'(x < y);
      alu_xor:      r = x ^ y;
      alu_srl:      r = x >> sh;
      alu_sra:      r = $signed(x) >>> sh;
      alu_or:       r = x | y;
      alu_and:      r = x & y;
      alu_lui_pass: r = y;
      default:      r = '0;
    endcase
    if (word) r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic logic model_taken(bj_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (op)
      bj_beq:          return a == b;
      bj_bne:          return a != b;
      bj_blt:          return $signed(a) < $signed(b);
      bj_bge:          return $signed(a) >= $signed(b);
      bj_bltu:         return a < b;
      bj_bgeu:         return a >= b;
      bj_jal, bj_jalr: return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_fail();
    end
  endtask

  task automatic check_mem(ex_to_mem_t got, ex_to_mem_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: ex_to_mem got %h expected %h", $time, got, exp);
      stop_on_fail();
    end
  endtask

  // target only matters while redirect is up
  task automatic check_bj(bj_ctrl_t got, bj_ctrl_t exp);
    if (got.redirect !== exp.redirect || (exp.redirect && got.target !== exp.target)) begin
      $display("CHECK FAILED at %0t: bj_ctrl got %h expected %h", $time, got, exp);
      stop_on_fail();
    end
  endtask

  task automatic drive_inputs();
    if (!id_to_ex_valid && in_count < n_instr && rand_bit(80)) begin
      id_to_ex       = new_instr();
      id_to_ex_valid = 1'b1;
    end
    // frozen while a finished result waits for memory
    if (!hold_fwd) begin
      mem_fwd = new_fwd(25);
      wb_fwd  = new_fwd(0);
    end
    mem_allowin = rand_bit(70);
  endtask

  task automatic check_cycle();
    id_to_ex_t       cur;
    logic [xlen-1:0] rs1_v, rs2_v, a, b;
    logic            busy, stall, out_exp, jump;
    ex_to_mem_t      mem_exp;
    bj_ctrl_t        bj_exp;
    busy = held_q.size() > 0;
    cur  = '0;
    if (busy) cur = held_q[0];
    stall   = busy && load_stall(cur);
    out_exp = busy && !stall;
    rs1_v   = pick_operand(cur.rs1_addr);
    rs2_v   = pick_operand(cur.rs2_addr);
    a       = cur.use_rs1 ? rs1_v : cur.op1;
    b       = cur.use_rs2 ? rs2_v : cur.op2;
    jump    = cur.bj_op == bj_jal || cur.bj_op == bj_jalr;
    accept_open = !busy || (!stall && mem_allowin);
    check_bit("ex_allowin", ex_allowin, accept_open);
    check_bit("ex_to_mem_valid", ex_to_mem_valid, out_exp);
    bj_exp.redirect = out_exp && model_taken(cur.bj_op, a, b);
    bj_exp.target   = (cur.bj_op == bj_jalr) ? ((rs1_v + cur.jmp_imm) & ~64'd1)
                                             : cur.pc + cur.jmp_imm;
    check_bj(bj_ctrl, bj_exp);
    if (out_exp) begin
      mem_exp.pc         = cur.pc;
      mem_exp.alu_result = jump ? cur.pc + 64'd4 : model_alu(cur.alu_op, a, b, cur.is_word);
      mem_exp.store_data = rs2_v;
      mem_exp.is_load    = cur.is_load;
      mem_exp.is_store   = cur.is_store;
      mem_exp.rd_wr_ena  = cur.rd_wr_ena;
      mem_exp.rd_addr    = cur.rd_addr;
      check_mem(ex_to_mem, mem_exp);
    end
    // transfers as the DUT shows them
    if (ex_to_mem_valid && mem_allowin) begin
      out_seen++;
    end
    xfer     = out_exp && mem_allowin;
    hold_fwd = out_exp && !mem_allowin;
  endtask

  // runs just after the edge and before new inputs are driven
  task automatic update_model();
    if (wb_fwd.valid && wb_fwd.wr_ena && wb_fwd.rd_addr != 0) begin
      shadow[wb_fwd.rd_addr] = wb_fwd.data;
    end
    if (xfer) begin
      void'(held_q.pop_front());
      out_count++;
    end
    if (accept_open && id_to_ex_valid) begin
      held_q.push_back(id_to_ex);
      in_count++;
      id_to_ex_valid = 1'b0;
    end
  endtask

  task automatic run_cycle();
    drive_inputs();
    @(negedge clk);
    check_cycle();
    @(posedge clk);
    #1;
    update_model();
  endtask

  initial begin
    seed           = 32'hf404;
    clk            = 1'b0;
    rst            = 1'b1;
    id_to_ex_valid = 1'b0;
    id_to_ex       = '0;
    mem_allowin    = 1'b0;
    mem_fwd        = '0;
    wb_fwd         = '0;
    cycles         = 0;
    in_count       = 0;
    out_count      = 0;
    out_seen       = 0;
    accept_open    = 1'b0;
    xfer           = 1'b0;
    hold_fwd       = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    while (out_count < n_instr) begin
      run_cycle();
    end
    // a few idle cycles so an extra result would show up
    repeat (4) begin
      run_cycle();
    end
    if (out_seen == in_count && in_count == n_instr && held_q.size() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("instruction count mismatch, %0d accepted and %0d came out",
               in_count, out_seen);
      stop_on_fail();
    end
  end

endmodule

`default_nettype wire

// ==== exec_properties.sv ====
// pipeline protocol assertions bound into the execute stage for simulation
`default_nettype none

module exec_properties import pipe_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       ex_allowin,
  input logic       ex_to_mem_valid,
  input ex_to_mem_t ex_to_mem,
  input logic       mem_allowin,
  input bj_ctrl_t   bj_ctrl
);

  timeunit 1ns;
  timeprecision 100ps;

  // stage comes out of reset empty
  assert property (@(posedge clk) rst |=> !ex_to_mem_valid && !bj_ctrl.redirect && ex_allowin)
    else $error("execute stage not empty after reset");

  // result and redirect hold while memory stalls
  assert property (@(posedge clk) disable iff (rst)
    ex_to_mem_valid && !mem_allowin |=>
      ex_to_mem_valid && $stable(ex_to_mem) && $stable(bj_ctrl))
    else $error("result changed under back-pressure");

  // a load-use stall keeps the instruction in place
  assert property (@(posedge clk) disable iff (rst)
    !ex_allowin && !ex_to_mem_valid |=>
      $stable(ex_to_mem.pc) && $stable(ex_to_mem.rd_addr))
    else $error("instruction replaced during a load-use stall");

endmodule

bind ex_stage exec_properties props_i (
  .clk             (clk),
  .rst             (rst),
  .ex_allowin      (ex_allowin),
  .ex_to_mem_valid (ex_to_mem_valid),
  .ex_to_mem       (ex_to_mem),
  .mem_allowin     (mem_allowin),
  .bj_ctrl         (bj_ctrl)
);

`default_nettype wire

// ==== exec_core.sv ====
// execute core top level joining the register file and the execute stage
`default_nettype none

module exec_core import rv_isa_pkg::*, pipe_pkg::*; #(
  parameter int reg_count = 32
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       id_to_ex_valid,
  input  id_to_ex_t  id_to_ex,
  output logic       ex_allowin,
  output logic       ex_to_mem_valid,
  output ex_to_mem_t ex_to_mem,
  input  logic       mem_allowin,
  input  fwd_t       mem_fwd,
  input  fwd_t       wb_fwd,
  output bj_ctrl_t   bj_ctrl
);

  logic [reg_addr_w-1:0] rs1_addr, rs2_addr;
  logic [xlen-1:0]       rs1_data, rs2_data;

  // writeback bus doubles as the register write port
  gpr_file #(
    .reg_count (reg_count)
  ) gpr_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (wb_fwd)
  );

  ex_stage ex_i (
    .clk             (clk),
    .rst             (rst),
    .id_to_ex_valid  (id_to_ex_valid),
    .id_to_ex        (id_to_ex),
    .ex_allowin      (ex_allowin),
    .ex_to_mem_valid (ex_to_mem_valid),
    .ex_to_mem       (ex_to_mem),
    .mem_allowin     (mem_allowin),
    .mem_fwd         (mem_fwd),
    .wb_fwd          (wb_fwd),
    .rs1_addr        (rs1_addr),
    .rs2_addr        (rs2_addr),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .bj_ctrl         (bj_ctrl)
  );

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
// execute stage: holds one instruction, forwards operands, runs the ALU and resolves branches
`default_nettype none

module ex_stage import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  id_to_ex_valid,
  input  id_to_ex_t             id_to_ex,
  output logic                  ex_allowin,
  output logic                  ex_to_mem_valid,
  output ex_to_mem_t            ex_to_mem,
  input  logic                  mem_allowin,
  input  fwd_t                  mem_fwd,
  input  fwd_t                  wb_fwd,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  output bj_ctrl_t              bj_ctrl
);

  logic            ex_valid;
  id_to_ex_t       inst_r;
  logic            hazard;
  logic            ready_go;
  logic [xlen-1:0] rs1_val, rs2_val;
  logic [xlen-1:0] alu_a, alu_b, alu_res;
  logic            lt_signed, lt_unsigned, equal;
  logic            taken;
  logic [xlen-1:0] bj_target;
  logic            is_jump;

  // handshake with decode and memory
  assign ready_go        = ~hazard;
  assign ex_allowin      = ~ex_valid || (ready_go && mem_allowin);
  assign ex_to_mem_valid = ex_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_to_ex_valid && ex_allowin) begin
      inst_r <= id_to_ex;
    end
  end

  assign rs1_addr = inst_r.rs1_addr;
  assign rs2_addr = inst_r.rs2_addr;

  forward_unit fwd_i (
    .rs1_addr (inst_r.rs1_addr),
    .rs2_addr (inst_r.rs2_addr),
    .use_rs1  (inst_r.use_rs1),
    .use_rs2  (inst_r.use_rs2),
    .rf_rs1   (rs1_data),
    .rf_rs2   (rs2_data),
    .mem_fwd  (mem_fwd),
    .wb_fwd   (wb_fwd),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .hazard   (hazard)
  );

  // register operand or decoded immediate
  assign alu_a = inst_r.use_rs1 ? rs1_val : inst_r.op1;
  assign alu_b = inst_r.use_rs2 ? rs2_val : inst_r.op2;

  ex_alu alu_i (
    .op1         (alu_a),
    .op2         (alu_b),
    .alu_op      (inst_r.alu_op),
    .is_word     (inst_r.is_word),
    .result      (alu_res),
    .lt_signed   (lt_signed),
    .lt_unsigned (lt_unsigned),
    .equal       (equal)
  );

  ex_branch bj_i (
    .bj_op       (inst_r.bj_op),
    .equal       (equal),
    .lt_signed   (lt_signed),
    .lt_unsigned (lt_unsigned),
    .pc          (inst_r.pc),
    .jmp_imm     (inst_r.jmp_imm),
    .rs1_val     (rs1_val),
    .taken       (taken),
    .target      (bj_target)
  );

  // jumps write the return address
  assign is_jump = (inst_r.bj_op == bj_jal) || (inst_r.bj_op == bj_jalr);

  assign ex_to_mem.pc         = inst_r.pc;
  assign ex_to_mem.alu_result = is_jump ? inst_r.pc + inst_bytes : alu_res;
  assign ex_to_mem.store_data = rs2_val;
  assign ex_to_mem.is_load    = inst_r.is_load;
  assign ex_to_mem.is_store   = inst_r.is_store;
  assign ex_to_mem.rd_wr_ena  = inst_r.rd_wr_ena;
  assign ex_to_mem.rd_addr    = inst_r.rd_addr;

  // redirect stays up with the result while memory holds it off
  assign bj_ctrl.redirect = ex_to_mem_valid && taken;
  assign bj_ctrl.target   = bj_target;

endmodule

`default_nettype wire

// ==== ex_branch.sv ====
// branch and jump resolution giving the taken flag and the redirect target
`default_nettype none

module ex_branch import rv_isa_pkg::*; (
  input  bj_op_e          bj_op,
  input  logic            equal,
  input  logic            lt_signed,
  input  logic            lt_unsigned,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] jmp_imm,
  input  logic [xlen-1:0] rs1_val,
  output logic            taken,
  output logic [xlen-1:0] target
);

  logic [xlen-1:0] jalr_sum;

  always_comb begin
    unique case (bj_op)
      bj_beq:          taken = equal;
      bj_bne:          taken = ~equal;
      bj_blt:          taken = lt_signed;
      bj_bge:          taken = ~lt_signed;
      bj_bltu:         taken = lt_unsigned;
      bj_bgeu:         taken = ~lt_unsigned;
      bj_jal, bj_jalr: taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_val + jmp_imm;

  // jalr drops bit 0 of the register-relative target
  assign target = (bj_op == bj_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc + jmp_imm;

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
// RV64 integer ALU with word operations and compare flags for branch resolution
`default_nettype none

module ex_alu import rv_isa_pkg::*; (
  input  logic [xlen-1:0] op1,
  input  logic [xlen-1:0] op2,
  input  alu_op_e         alu_op,
  input  logic            is_word,
  output logic [xlen-1:0] result,
  output logic            lt_signed,
  output logic            lt_unsigned,
  output logic            equal
);

  logic [31:0]     a_w, b_w, res_w;
  logic [4:0]      sh_w;
  logic [5:0]      sh_d;
  logic [xlen-1:0] res_d;

  assign a_w  = op1[31:0];
  assign b_w  = op2[31:0];
  assign sh_w = op2[4:0];
  assign sh_d = op2[5:0];

  // full width path
  always_comb begin
    unique case (alu_op)
      alu_add:      res_d = op1 + op2;
      alu_sub:      res_d = op1 - op2;
      alu_sll:      res_d = op1 << sh_d;
      alu_slt:      res_d = {63'b0, $signed(op1) < $signed(op2)};
      alu_sltu:     res_d = {63'b0, op1 < op2};
      alu_xor:      res_d = op1 ^ op2;
      alu_srl:      res_d = op1 >> sh_d;
      alu_sra:      res_d = $signed(op1) >>> sh_d;
      alu_or:       res_d = op1 | op2;
      alu_and:      res_d = op1 & op2;
      alu_lui_pass: res_d = op2;
      default:      res_d = '0;
    endcase
  end

  // word path on the low halves
  always_comb begin
    unique case (alu_op)
      alu_add:      res_w = a_w + b_w;
      alu_sub:      res_w = a_w - b_w;
      alu_sll:      res_w = a_w << sh_w;
      alu_slt:      res_w = {31'b0, $signed(a_w) < $signed(b_w)};
      alu_sltu:     res_w = {31'b0, a_w < b_w};
      alu_xor:      res_w = a_w ^ b_w;
      alu_srl:      res_w = a_w >> sh_w;
      alu_sra:      res_w = $signed(a_w) >>> sh_w;
      alu_or:       res_w = a_w | b_w;
      alu_and:      res_w = a_w & b_w;
      alu_lui_pass: res_w = b_w;
      default:      res_w = '0;
    endcase
  end

  assign result = is_word ? {{32{res_w[31]}}, res_w} : res_d;

  // branch flags always compare the full operands
  assign lt_signed   = $signed(op1) < $signed(op2);
  assign lt_unsigned = op1 < op2;
  assign equal       = op1 == op2;

endmodule

`default_nettype wire

// ==== forward_unit.sv ====
// operand forwarding from mem and wb with load-use detection, used inside the execute stage
`default_nettype none

module forward_unit import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic [reg_addr_w-1:0] rs1_addr,
  input  logic [reg_addr_w-1:0] rs2_addr,
  input  logic                  use_rs1,
  input  logic                  use_rs2,
  input  logic [xlen-1:0]       rf_rs1,
  input  logic [xlen-1:0]       rf_rs2,
  input  fwd_t                  mem_fwd,
  input  fwd_t                  wb_fwd,
  output logic [xlen-1:0]       rs1_val,
  output logic [xlen-1:0]       rs2_val,
  output logic                  hazard
);

  logic mem_hit1, mem_hit2;
  logic wb_hit1, wb_hit2;

  function automatic logic src_match(fwd_t src, logic [reg_addr_w-1:0] addr);
    return src.valid && src.wr_ena && (src.rd_addr == addr) && (addr != '0);
  endfunction

  assign mem_hit1 = src_match(mem_fwd, rs1_addr);
  assign mem_hit2 = src_match(mem_fwd, rs2_addr);
  assign wb_hit1  = src_match(wb_fwd, rs1_addr);
  assign wb_hit2  = src_match(wb_fwd, rs2_addr);

  // newest first: mem, then wb, then the register file
  assign rs1_val = mem_hit1 ? mem_fwd.data :
                   wb_hit1  ? wb_fwd.data  : rf_rs1;
  assign rs2_val = mem_hit2 ? mem_fwd.data :
                   wb_hit2  ? wb_fwd.data  : rf_rs2;

  // load data not back yet, only counts for operands in use
  assign hazard = mem_fwd.is_load &&
                  ((use_rs1 && mem_hit1) || (use_rs2 && mem_hit2));

endmodule

`default_nettype wire

// ==== gpr_file.sv ====
// general register file with two combinational read ports, written from the writeback bus
`default_nettype none

module gpr_file import rv_isa_pkg::*, pipe_pkg::*; #(
  parameter int reg_count = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [reg_addr_w-1:0] rs1_addr,
  input  logic [reg_addr_w-1:0] rs2_addr,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data,
  input  fwd_t                  wr
);

  localparam int idx_w = $clog2(reg_count);
  localparam logic [reg_addr_w:0] reg_limit = (reg_addr_w + 1)'(reg_count);

  logic [xlen-1:0] regs [reg_count];
  logic            wr_hit;

  // x0 and indices past the array are never written
  assign wr_hit = wr.valid && wr.wr_ena && (wr.rd_addr != '0) &&
                  ({1'b0, wr.rd_addr} < reg_limit);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[wr.rd_addr[idx_w-1:0]] <= wr.data;
    end
  end

  // reads see the old value during a write, wb forwarding covers that
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if ((rs1_addr != '0) && ({1'b0, rs1_addr} < reg_limit)) begin
      rs1_data = regs[rs1_addr[idx_w-1:0]];
    end
    if ((rs2_addr != '0) && ({1'b0, rs2_addr} < reg_limit)) begin
      rs2_data = regs[rs2_addr[idx_w-1:0]];
    end
  end

endmodule

`default_nettype wire

// ==== pipe_pkg.sv ====
// bus structs passed between decode, execute, memory and writeback stages
`default_nettype none

package pipe_pkg;

  import rv_isa_pkg::*;

  // decoded instruction from decode
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic                  use_rs1;
    logic                  use_rs2;
    logic [xlen-1:0]       op1;
    logic [xlen-1:0]       op2;
    logic                  is_word;
    alu_op_e               alu_op;
    bj_op_e                bj_op;
    logic [xlen-1:0]       jmp_imm;
    logic                  is_load;
    logic                  is_store;
    logic                  rd_wr_ena;
    logic [reg_addr_w-1:0] rd_addr;
  } id_to_ex_t;

  // execute result towards the memory stage
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       store_data;
    logic                  is_load;
    logic                  is_store;
    logic                  rd_wr_ena;
    logic [reg_addr_w-1:0] rd_addr;
  } ex_to_mem_t;

  // forwarding source from a later stage
  typedef struct packed {
    logic                  valid;
    logic                  wr_ena;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       data;
    logic                  is_load;
  } fwd_t;

  // redirect for fetch
  typedef struct packed {
    logic            redirect;
    logic [xlen-1:0] target;
  } bj_ctrl_t;

endpackage

`default_nettype wire

// ==== rv_isa_pkg.sv ====
// RV64 integer constants and operation encodings, imported by the execute core and its testbench
`default_nettype none

package rv_isa_pkg;

  // register width and register index width
  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;

  // fixed instruction size, used for the link value of jal/jalr
  localparam logic [xlen-1:0] inst_bytes = 64'd4;

  // ALU operations
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_lui_pass
  } alu_op_e;

  // branch and jump kinds, bj_none for plain ALU work
  typedef enum logic [3:0] {
    bj_none,
    bj_beq,
    bj_bne,
    bj_blt,
    bj_bge,
    bj_bltu,
    bj_bgeu,
    bj_jal,
    bj_jalr
  } bj_op_e;

endpackage

`default_nettype wire
